//--- include/mxnorm_config.svh
`ifndef MXNORM_CONFIG_SVH
`define MXNORM_CONFIG_SVH

// Mantissa and exponent widths, exponent is signed
`define MX_MAN_WIDTH 8
`define MX_EXP_WIDTH 4

// Mantissas carried by one beat
`define MX_BLOCK_SIZE 2

// Beats per row
`define MX_ROW_DEPTH 2

// log2(MX_BLOCK_SIZE * MX_ROW_DEPTH), used for the mean shift
`define MX_ROW_LEN_LOG2 2

`endif

//--- run.sh
#!/bin/sh
# Build and run the row-center testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mxint_row_center -f tb.f -o sim_tb_mxint_row_center
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb_mxint_row_center +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- sim/mxint_row_center_checker.sv
`timescale 1ns/1ps

module mxint_row_center_checker import mxnorm_pkg::*; (
    input logic   clk,
    input logic   arst_n,
    input logic   in_ready,
    input logic   out_valid,
    input logic   out_ready,
    input block_t out_man,
    input exp_t   out_exp
);

    int unsigned fail_count = 0;

    // Stalled output beat must hold until taken
    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_man) && $stable(out_exp))
        else begin
            $error("output beat changed while out_ready was low");
            fail_count++;
        end

    out_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(out_valid))
        else begin
            $error("out_valid is unknown after reset");
            fail_count++;
        end

    // First cycle out of reset, stage 1 is filling
    ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> in_ready)
        else begin
            $error("in_ready low in the cycle after reset release");
            fail_count++;
        end

endmodule

bind mxint_row_center mxint_row_center_checker u_checker (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_man  (out_man),
    .out_exp  (out_exp)
);

//--- sim/row_center_stim.txt
// Columns: in_man[1] in_man[0] in_exp, then expected out_man[1] out_man[0] out_exp
// 10 hex digits per beat, two beats per row, beat 0 first
C8402EDFC5
2010514045
9C35801027
F00C7F20E7
2020100003
0808300003
7F7F040400
807F080400
80802C1C12
7F8027FC12
E264DE304F
50F6F3BE1F
EF116F0126
817F1FD046
7F80D01004
FB054FC064
D83C7D4387
807FFFBFC7
0201800FF8
0403802018

//--- sim/tb_mxint_row_center.sv
`timescale 1ns/1ps

module tb_mxint_row_center import mxnorm_pkg::*; ();

    localparam int NUM_BEATS      = 20;
    localparam int TIMEOUT_CYCLES = 40 * NUM_BEATS;

    logic   clk;
    logic   arst_n;
    logic   in_valid;
    logic   in_ready;
    block_t in_man;
    exp_t   in_exp;
    logic   out_valid;
    logic   out_ready;
    block_t out_man;
    exp_t   out_exp;

    // {in_man, in_exp, expected out_man, expected out_exp}
    logic [39:0] stim_mem [NUM_BEATS];

    int   seed;
    logic running       = 1'b0;
    int   beat_idx      = 0;   // Next input beat to present
    int   out_idx       = 0;   // Next expected output beat
    int   cycle_count   = 0;
    int   error_count   = 0;
    int   timeout_count = 0;
    int   assert_count;

    mxint_row_center uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_man   (in_man),
        .in_exp   (in_exp),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_man  (out_man),
        .out_exp  (out_exp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Input driver and output back-pressure, one random stream
    always @(posedge clk) begin
        if (running) begin
            out_ready <= ($random(seed) & 1) != 0;
            if (!in_valid || in_ready) begin  // Nothing pending or it just moved
                if (beat_idx < NUM_BEATS && ($random(seed) & 3) != 0) begin
                    in_valid <= 1'b1;
                    in_man   <= stim_mem[beat_idx][39:24];
                    in_exp   <= stim_mem[beat_idx][23:20];
                    beat_idx <= beat_idx + 1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    // Output monitor
    always @(posedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            if (out_idx < NUM_BEATS) begin
                assert (out_man == stim_mem[out_idx][19:4]) else begin
                    $display("CHECK FAILED at %0t: beat %0d out_man %h, expected %h",
                             $time, out_idx, out_man, stim_mem[out_idx][19:4]);
                    error_count++;
                end
                assert (out_exp == stim_mem[out_idx][3:0]) else begin
                    $display("CHECK FAILED at %0t: beat %0d out_exp %h, expected %h",
                             $time, out_idx, out_exp, stim_mem[out_idx][3:0]);
                    error_count++;
                end
            end else begin
                $display("Unexpected extra output beat %0d at %0t", out_idx, $time);
                error_count++;
            end
            out_idx <= out_idx + 1;
        end
    end

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_man    = '0;
        in_exp    = '0;
        out_ready = 1'b0;
        seed      = 32'h4722_188b;

        for (int i = 0; i < NUM_BEATS; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("sim/row_center_stim.txt", stim_mem);
        // No real entry is all zeros
        for (int i = 0; i < NUM_BEATS; i++) begin
            assert (stim_mem[i] != '0) else begin
                $display("Stimulus entry %0d is missing from the stim file", i);
                error_count++;
            end
        end

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);
        assert (out_valid == 1'b0) else begin
            $display("CHECK FAILED at %0t: out_valid high after reset", $time);
            error_count++;
        end
        assert (in_ready == 1'b1) else begin
            $display("CHECK FAILED at %0t: in_ready low after reset", $time);
            error_count++;
        end
        running = 1'b1;

        while (out_idx < NUM_BEATS && cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (out_idx < NUM_BEATS) begin
            $display("Timeout after %0d cycles, only %0d of %0d output beats received",
                     cycle_count, out_idx, NUM_BEATS);
            timeout_count++;
        end

        repeat (5) @(posedge clk);  // Catch stray beats
        assert_count = uut.u_checker.fail_count;
        $display("Errors: %0d check failures, %0d assertion failures, %0d timeouts",
                 error_count, assert_count, timeout_count);
        if (error_count == 0 && assert_count == 0 && timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src/mx_row_align.sv
`timescale 1ns/1ps
`include "mxnorm_config.svh"

module mx_row_align import mxnorm_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    mx_stream_if.sink   in,
    mx_stream_if.source out
);

    localparam exp_t EXP_MIN = exp_t'({1'b1, {(`MX_EXP_WIDTH - 1){1'b0}}});

    mx_stream_if buffered ();

    logic                          in_fire;
    logic                          last_write;
    exp_t                          run_max;
    exp_t                          next_max;
    exp_t                          row_max;
    logic signed [`MX_EXP_WIDTH:0] shift_amt;
    block_t                        shifted;

    // Mantissas wait here until the row max is known
    mx_row_buffer u_row_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (in),
        .rd        (buffered.source),
        .last_write(last_write)
    );

    assign in_fire  = in.valid && in.ready;
    assign next_max = (in.exp > run_max) ? in.exp : run_max;

    // Running max over the beats written so far
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_max <= EXP_MIN;
        end else if (last_write) begin
            run_max <= EXP_MIN;  // Next row starts over
        end else if (in_fire) begin
            run_max <= next_max;
        end
    end

    // Held for the whole replay, the buffer blocks new writes meanwhile
    always_ff @(posedge clk) begin
        if (last_write) begin
            row_max <= next_max;
        end
    end

    // Never negative since row_max covers every beat
    assign shift_amt = row_max - buffered.exp;

    always_comb begin
        for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
            if (shift_amt >= `MX_MAN_WIDTH) begin
                // Shifted out entirely, only the sign is left
                shifted[i] = {`MX_MAN_WIDTH{buffered.man[i][`MX_MAN_WIDTH-1]}};
            end else begin
                shifted[i] = buffered.man[i] >>> shift_amt;
            end
        end
    end

    assign out.valid      = buffered.valid;
    assign out.man        = shifted;
    assign out.exp        = row_max;   // Same exponent on every beat of the row
    assign buffered.ready = out.ready;

endmodule

//--- src/mx_row_buffer.sv
`timescale 1ns/1ps
`include "mxnorm_config.svh"

module mx_row_buffer import mxnorm_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    mx_stream_if.sink   wr,
    mx_stream_if.source rd,
    output logic        last_write
);

    localparam row_idx_t LAST_IDX = row_idx_t'(`MX_ROW_DEPTH - 1);

    block_t   man_mem [`MX_ROW_DEPTH];
    exp_t     exp_mem [`MX_ROW_DEPTH];

    row_idx_t idx;       // Write slot while filling, read slot while draining
    logic     draining;
    logic     wr_fire;
    logic     rd_fire;

    // Only one side is open at a time
    assign wr.ready = !draining;
    assign rd.valid = draining;

    assign wr_fire = wr.valid && wr.ready;
    assign rd_fire = rd.valid && rd.ready;

    assign last_write = wr_fire && (idx == LAST_IDX);

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            man_mem[idx] <= wr.man;
            exp_mem[idx] <= wr.exp;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx      <= '0;
            draining <= 1'b0;
        end else if (wr_fire || rd_fire) begin
            if (idx == LAST_IDX) begin
                idx      <= '0;
                draining <= !draining;  // Row complete on either side
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Replay in write order
    assign rd.man = man_mem[idx];
    assign rd.exp = exp_mem[idx];

endmodule

//--- src/mx_stream_if.sv
`timescale 1ns/1ps

// Block stream, beat moves when valid and ready are both high
interface mx_stream_if import mxnorm_pkg::*; ();

    logic   valid;
    block_t man;
    exp_t   exp;
    logic   ready;

    modport source (
        output valid,
        output man,
        output exp,
        input  ready
    );

    modport sink (
        input  valid,
        input  man,
        input  exp,
        output ready
    );

endinterface

//--- src/mxint_row_center.sv
`timescale 1ns/1ps

module mxint_row_center import mxnorm_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,

    input  logic   in_valid,
    output logic   in_ready,
    input  block_t in_man,
    input  exp_t   in_exp,

    output logic   out_valid,
    input  logic   out_ready,
    output block_t out_man,
    output exp_t   out_exp
);

    mx_stream_if in_s ();
    mx_stream_if aligned ();
    mx_stream_if out_s ();

    assign in_s.valid = in_valid;
    assign in_s.man   = in_man;
    assign in_s.exp   = in_exp;
    assign in_ready   = in_s.ready;

    // Stage 1, shift every beat to the row max exponent
    mx_row_align u_row_align (
        .clk   (clk),
        .arst_n(arst_n),
        .in    (in_s.sink),
        .out   (aligned.source)
    );

    // Stage 2, subtract the row mean
    row_mean_center u_mean_center (
        .clk   (clk),
        .arst_n(arst_n),
        .in    (aligned.sink),
        .out   (out_s.source)
    );

    assign out_valid   = out_s.valid;
    assign out_man     = out_s.man;
    assign out_exp     = out_s.exp;
    assign out_s.ready = out_ready;

endmodule

//--- src/mxnorm_pkg.sv
`include "mxnorm_config.svh"

package mxnorm_pkg;

    // One signed mantissa
    typedef logic signed [`MX_MAN_WIDTH-1:0] man_t;

    // Shared block exponent, signed
    typedef logic signed [`MX_EXP_WIDTH-1:0] exp_t;

    // All mantissas of a beat, element 0 in the low bits
    typedef man_t [`MX_BLOCK_SIZE-1:0] block_t;

    // Beat position inside a row
    typedef logic [$clog2(`MX_ROW_DEPTH)-1:0] row_idx_t;

    // Sum of every mantissa in a row, wide enough not to overflow
    typedef logic signed [`MX_MAN_WIDTH+`MX_ROW_LEN_LOG2-1:0] row_sum_t;

endpackage

//--- src/row_mean_center.sv
`timescale 1ns/1ps
`include "mxnorm_config.svh"

module row_mean_center import mxnorm_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    mx_stream_if.sink   in,
    mx_stream_if.source out
);

    localparam man_t MAN_MAX = man_t'({1'b0, {(`MX_MAN_WIDTH - 1){1'b1}}});
    localparam man_t MAN_MIN = man_t'({1'b1, {(`MX_MAN_WIDTH - 1){1'b0}}});

    mx_stream_if buffered ();

    logic     in_fire;
    logic     last_write;
    row_sum_t beat_sum;
    row_sum_t acc;
    row_sum_t row_sum;
    row_sum_t mean_wide;
    man_t     mean;
    block_t   centered;

    mx_row_buffer u_row_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (in),
        .rd        (buffered.source),
        .last_write(last_write)
    );

    assign in_fire = in.valid && in.ready;

    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
            beat_sum = beat_sum + row_sum_t'(in.man[i]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (last_write) begin
            acc <= '0;
        end else if (in_fire) begin
            acc <= acc + beat_sum;
        end
    end

    // Final beat folded in directly
    always_ff @(posedge clk) begin
        if (last_write) begin
            row_sum <= acc + beat_sum;
        end
    end

    // Floor division by the row length
    assign mean_wide = row_sum >>> `MX_ROW_LEN_LOG2;
    assign mean      = man_t'(mean_wide);  // Always in mantissa range

    always_comb begin
        logic signed [`MX_MAN_WIDTH:0] diff;
        for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
            diff = buffered.man[i] - mean;
            if (diff[`MX_MAN_WIDTH] != diff[`MX_MAN_WIDTH-1]) begin
                // Out of range, clamp by sign
                centered[i] = diff[`MX_MAN_WIDTH] ? MAN_MIN : MAN_MAX;
            end else begin
                centered[i] = man_t'(diff);
            end
        end
    end

    assign out.valid      = buffered.valid;
    assign out.man        = centered;
    assign out.exp        = buffered.exp;
    assign buffered.ready = out.ready;

endmodule

//--- tb.f
+incdir+include
src/mxnorm_pkg.sv
src/mx_stream_if.sv
src/mx_row_buffer.sv
src/mx_row_align.sv
src/row_mean_center.sv
src/mxint_row_center.sv
sim/mxint_row_center_checker.sv
sim/tb_mxint_row_center.sv
